/* hw/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// datapath widths, fixed by the MIPS32 encoding
`define WORD_W 32
`define REG_IDX_W 5
`define EXC_W 5

// link register for jal, jalr, bgezal, bltzal
`define LINK_REG 31

// exception codes
`define EXC_SYS 8
`define EXC_BP 9
`define EXC_RI 10

// bus register byte addresses
`define ADDR_INST 8'h00
`define ADDR_PC 8'h04
`define ADDR_RS 8'h08
`define ADDR_RT 8'h0C
`define ADDR_FEXC 8'h10
`define ADDR_CTRL 8'h14
`define ADDR_ALU_A 8'h18
`define ADDR_ALU_B 8'h1C
`define ADDR_TARGET 8'h20
`define ADDR_DEST 8'h24

// field positions in the DEST read value
`define DEST_WE_BIT 8
`define DEST_EXC_LSB 16

`endif

/* hw/decode_pkg.sv */
`default_nettype none
`include "decode_params.svh"

package decode_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`EXC_W-1:0] exc_code_t;
    typedef logic [7:0] bus_addr_t;

    // one-hot operation flags, op_add sits at bit 0
    typedef struct packed {
        logic branch_jump;
        logic jump;
        logic br_gez;
        logic br_ltz;
        logic br_lez;
        logic br_gtz;
        logic br_ne;
        logic br_eq;
        logic op_link;
        logic op_srl;
        logic op_sra;
        logic op_sll;
        logic op_xor;
        logic op_or;
        logic op_nor;
        logic op_lui;
        logic op_and;
        logic op_sltu;
        logic op_slt;
        logic op_subu;
        logic op_sub;
        logic op_addu;
        logic op_add;
    } decode_ctrl_t;

    // ack handshake
    typedef enum logic [0:0] {
        BUS_IDLE,
        BUS_ACK
    } bus_state_t;

endpackage

`default_nettype wire

/* hw/inst_classify.sv */
`default_nettype none
`include "decode_params.svh"

module inst_classify
    import decode_pkg::*;
(
    input  wire word_t     inst,
    input  wire word_t     pc,
    input  wire exc_code_t fetch_exc,
    output decode_ctrl_t   ctrl,
    output logic           write_reg,
    output exc_code_t      exc_code
);

    wire [5:0] opcode = inst[31:26];
    wire [5:0] funct = inst[5:0];
    wire [4:0] sa = inst[10:6];
    wire reg_idx_t rs = inst[25:21];
    wire reg_idx_t rt = inst[20:16];
    wire reg_idx_t rd = inst[15:11];

    // nothing decodes from a misaligned fetch
    wire aligned = (pc[1:0] == 2'b00);
    wire special = aligned & (opcode == 6'b000000);
    wire regimm = aligned & (opcode == 6'b000001);
    wire r_alu = special & (sa == 5'd0);
    wire r_shift = special & (rs == 5'd0);

    wire m_add = r_alu & (funct == 6'b100000);
    wire m_addu = r_alu & (funct == 6'b100001);
    wire m_sub = r_alu & (funct == 6'b100010);
    wire m_subu = r_alu & (funct == 6'b100011);
    wire m_and = r_alu & (funct == 6'b100100);
    wire m_or = r_alu & (funct == 6'b100101);
    wire m_xor = r_alu & (funct == 6'b100110);
    wire m_nor = r_alu & (funct == 6'b100111);
    wire m_slt = r_alu & (funct == 6'b101010);
    wire m_sltu = r_alu & (funct == 6'b101011);
    wire m_sll = r_shift & (funct == 6'b000000);
    wire m_srl = r_shift & (funct == 6'b000010);
    wire m_sra = r_shift & (funct == 6'b000011);
    wire m_sllv = r_alu & (funct == 6'b000100);
    wire m_srlv = r_alu & (funct == 6'b000110);
    wire m_srav = r_alu & (funct == 6'b000111);
    wire m_jr = r_alu & (rt == 5'd0) & (rd == 5'd0) & (funct == 6'b001000);
    wire m_jalr = r_alu & (rt == 5'd0) & (funct == 6'b001001);
    wire m_syscall = special & (funct == 6'b001100);
    wire m_break = special & (funct == 6'b001101);

    wire m_addi = aligned & (opcode == 6'b001000);
    wire m_addiu = aligned & (opcode == 6'b001001);
    wire m_slti = aligned & (opcode == 6'b001010);
    wire m_sltiu = aligned & (opcode == 6'b001011);
    wire m_andi = aligned & (opcode == 6'b001100);
    wire m_ori = aligned & (opcode == 6'b001101);
    wire m_xori = aligned & (opcode == 6'b001110);
    wire m_lui = aligned & (opcode == 6'b001111) & (rs == 5'd0);

    wire m_beq = aligned & (opcode == 6'b000100);
    wire m_bne = aligned & (opcode == 6'b000101);
    wire m_blez = aligned & (opcode == 6'b000110) & (rt == 5'd0);
    wire m_bgtz = aligned & (opcode == 6'b000111) & (rt == 5'd0);
    wire m_bltz = regimm & (rt == 5'b00000);
    wire m_bgez = regimm & (rt == 5'b00001);
    wire m_bltzal = regimm & (rt == 5'b10000);
    wire m_bgezal = regimm & (rt == 5'b10001);
    wire m_j = aligned & (opcode == 6'b000010);
    wire m_jal = aligned & (opcode == 6'b000011);

    always_comb
    begin
        ctrl.op_add = m_add | m_addi;
        ctrl.op_addu = m_addu | m_addiu;
        ctrl.op_sub = m_sub;
        ctrl.op_subu = m_subu;
        ctrl.op_slt = m_slt | m_slti;
        ctrl.op_sltu = m_sltu | m_sltiu;
        ctrl.op_and = m_and | m_andi;
        ctrl.op_lui = m_lui;
        ctrl.op_nor = m_nor;
        ctrl.op_or = m_or | m_ori;
        ctrl.op_xor = m_xor | m_xori;
        ctrl.op_sll = m_sll | m_sllv;
        ctrl.op_sra = m_sra | m_srav;
        ctrl.op_srl = m_srl | m_srlv;
        ctrl.op_link = m_jal | m_jalr | m_bgezal | m_bltzal;
        ctrl.br_eq = m_beq;
        ctrl.br_ne = m_bne;
        ctrl.br_gtz = m_bgtz;
        ctrl.br_lez = m_blez;
        ctrl.br_ltz = m_bltz | m_bltzal;
        ctrl.br_gez = m_bgez | m_bgezal;
        ctrl.jump = m_j | m_jal | m_jr | m_jalr;
        ctrl.branch_jump = ctrl.br_eq | ctrl.br_ne | ctrl.br_gtz | ctrl.br_lez
                         | ctrl.br_ltz | ctrl.br_gez | ctrl.jump;
    end

    // every ALU and shift flag plus the link forms
    assign write_reg = (|ctrl[14:0]);

    always_comb
    begin
        if (m_break)
            exc_code = `EXC_BP;
        else if (m_syscall)
            exc_code = `EXC_SYS;
        else if (aligned & ~(|ctrl))
            exc_code = `EXC_RI;
        else
            exc_code = fetch_exc;
    end

endmodule

`default_nettype wire

/* hw/operand_select.sv */
`default_nettype none
`include "decode_params.svh"

module operand_select
    import decode_pkg::*;
(
    input  wire word_t          inst,
    input  wire word_t          rs_value,
    input  wire word_t          rt_value,
    input  wire decode_ctrl_t   ctrl,
    output word_t               alu_a,
    output word_t               alu_b,
    output reg_idx_t            dest
);

    wire [5:0] opcode = inst[31:26];
    wire [15:0] imm = inst[15:0];
    wire [4:0] sa = inst[10:6];

    // immediate forms have a nonzero opcode
    wire is_imm = (opcode != 6'b000000);
    wire is_shift = ctrl.op_sll | ctrl.op_sra | ctrl.op_srl;
    // funct bit 2 marks sllv, srlv, srav
    wire shift_var = inst[2];
    wire is_alu = ctrl.op_add | ctrl.op_addu | ctrl.op_sub | ctrl.op_subu | ctrl.op_slt
                | ctrl.op_sltu | ctrl.op_and | ctrl.op_nor | ctrl.op_or | ctrl.op_xor;

    assign alu_a = is_shift ? rt_value : rs_value;

    always_comb
    begin
        if (is_imm & (ctrl.op_add | ctrl.op_addu | ctrl.op_slt | ctrl.op_sltu))
            alu_b = {{(`WORD_W-16){imm[15]}}, imm};
        else if (is_imm & (ctrl.op_and | ctrl.op_or | ctrl.op_xor))
            alu_b = {{(`WORD_W-16){1'b0}}, imm};
        else if (ctrl.op_lui)
            alu_b = {imm, 16'h0000};
        else if (is_shift & ~shift_var)
            alu_b = {{(`WORD_W-5){1'b0}}, sa};
        else if (is_shift)
            alu_b = rs_value;
        else
            alu_b = rt_value;
    end

    always_comb
    begin
        if (~is_imm & (is_alu | is_shift))
            dest = inst[15:11];
        else if (ctrl.op_link)
            dest = `LINK_REG;
        else
            dest = inst[20:16];
    end

endmodule

`default_nettype wire

/* hw/branch_target.sv */
`default_nettype none
`include "decode_params.svh"

module branch_target
    import decode_pkg::*;
(
    input  wire word_t        inst,
    input  wire word_t        pc,
    input  wire word_t        rs_value,
    input  wire decode_ctrl_t ctrl,
    output word_t             target
);

    wire [15:0] offset = inst[15:0];
    wire word_t delay_slot = pc + 32'd4;
    wire word_t branch_addr = delay_slot + {{14{offset[15]}}, offset, 2'b00};

    wire is_branch = ctrl.br_eq | ctrl.br_ne | ctrl.br_gtz | ctrl.br_lez
                   | ctrl.br_ltz | ctrl.br_gez;
    // jr and jalr live in the special opcode
    wire is_reg_jump = ctrl.jump & (inst[31:26] == 6'b000000);

    always_comb
    begin
        if (is_branch)
            target = branch_addr;
        else if (is_reg_jump)
            target = rs_value;
        else if (ctrl.jump)
            target = {delay_slot[31:28], inst[25:0], 2'b00};
        else
            target = '0;
    end

endmodule

`default_nettype wire

/* hw/decode_regs.sv */
`default_nettype none
`include "decode_params.svh"

module decode_regs
    import decode_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire            wb_cyc,
    input  wire            wb_stb,
    input  wire            wb_we,
    input  wire bus_addr_t wb_adr,
    input  wire word_t     wb_dat_w,
    input  wire decode_ctrl_t ctrl,
    input  wire            write_reg,
    input  wire exc_code_t exc_code,
    input  wire word_t     alu_a,
    input  wire word_t     alu_b,
    input  wire reg_idx_t  dest,
    input  wire word_t     target,
    output word_t          wb_dat_r,
    output logic           wb_ack,
    output word_t          inst,
    output word_t          pc,
    output word_t          rs_value,
    output word_t          rt_value,
    output exc_code_t      fetch_exc
);

    bus_state_t state;
    logic req;
    word_t rd_mux;
    word_t dest_word;

    // only accept while idle, so every access costs two cycles
    assign req = wb_cyc & wb_stb & (state == BUS_IDLE);
    assign wb_ack = (state == BUS_ACK);

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= BUS_IDLE;
        else
        begin
            case (state)
                BUS_IDLE:
                begin
                    if (req)
                        state <= BUS_ACK;
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            inst <= '0;
            pc <= '0;
            rs_value <= '0;
            rt_value <= '0;
            fetch_exc <= '0;
        end
        else if (req & wb_we)
        begin
            case (wb_adr)
                `ADDR_INST: inst <= wb_dat_w;
                `ADDR_PC: pc <= wb_dat_w;
                `ADDR_RS: rs_value <= wb_dat_w;
                `ADDR_RT: rt_value <= wb_dat_w;
                `ADDR_FEXC: fetch_exc <= wb_dat_w[`EXC_W-1:0];
                default: ;
            endcase
        end
    end

    always_comb
    begin
        dest_word = '0;
        dest_word[`REG_IDX_W-1:0] = dest;
        dest_word[`DEST_WE_BIT] = write_reg;
        dest_word[`DEST_EXC_LSB +: `EXC_W] = exc_code;
    end

    always_comb
    begin
        case (wb_adr)
            `ADDR_INST: rd_mux = inst;
            `ADDR_PC: rd_mux = pc;
            `ADDR_RS: rd_mux = rs_value;
            `ADDR_RT: rd_mux = rt_value;
            `ADDR_FEXC: rd_mux = word_t'(fetch_exc);
            `ADDR_CTRL: rd_mux = word_t'(ctrl);
            `ADDR_ALU_A: rd_mux = alu_a;
            `ADDR_ALU_B: rd_mux = alu_b;
            `ADDR_TARGET: rd_mux = target;
            `ADDR_DEST: rd_mux = dest_word;
            default: rd_mux = '0;
        endcase
    end

    // read data captured with the request, held through the ack
    always_ff @(posedge clk)
    begin
        if (req)
            wb_dat_r <= rd_mux;
    end

endmodule

`default_nettype wire

/* hw/decode_top.sv */
`default_nettype none
`include "decode_params.svh"

module decode_top
    import decode_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire            wb_cyc,
    input  wire            wb_stb,
    input  wire            wb_we,
    input  wire bus_addr_t wb_adr,
    input  wire word_t     wb_dat_w,
    output word_t          wb_dat_r,
    output logic           wb_ack
);

    word_t inst;
    word_t pc;
    word_t rs_value;
    word_t rt_value;
    exc_code_t fetch_exc;
    decode_ctrl_t ctrl;
    logic write_reg;
    exc_code_t exc_code;
    word_t alu_a;
    word_t alu_b;
    reg_idx_t dest;
    word_t target;

    decode_regs i_regs (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .ctrl(ctrl), .write_reg(write_reg), .exc_code(exc_code),
        .alu_a(alu_a), .alu_b(alu_b), .dest(dest), .target(target),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .inst(inst), .pc(pc), .rs_value(rs_value), .rt_value(rt_value),
        .fetch_exc(fetch_exc)
    );

    inst_classify i_classify (
        .inst(inst), .pc(pc), .fetch_exc(fetch_exc),
        .ctrl(ctrl), .write_reg(write_reg), .exc_code(exc_code)
    );

    operand_select i_operands (
        .inst(inst), .rs_value(rs_value), .rt_value(rt_value), .ctrl(ctrl),
        .alu_a(alu_a), .alu_b(alu_b), .dest(dest)
    );

    branch_target i_target (
        .inst(inst), .pc(pc), .rs_value(rs_value), .ctrl(ctrl),
        .target(target)
    );

endmodule

`default_nettype wire

/* bench/decode_properties.sv */
`default_nettype none
`include "decode_params.svh"

module decode_properties
    import decode_pkg::*;
(
    input wire clk,
    input wire reset,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_ack
);

    // ack only answers a request from the previous edge
    ack_after_request: assert property (@(posedge clk) disable iff (reset)
        $rose(wb_ack) |-> $past(wb_cyc & wb_stb))
        else $error("ack rose without cyc and stb in the previous cycle");

    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("ack held high for two cycles");

    ack_low_after_reset: assert property (@(posedge clk)
        reset |=> !wb_ack)
        else $error("ack high in the cycle after reset");

endmodule

bind decode_regs decode_properties i_props (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack)
);

`default_nettype wire

/* bench/decode_tb.sv */
`default_nettype none
`include "decode_params.svh"

module decode_tb
    import decode_pkg::*;
();

    // about 170 accesses of 2 cycles each plus a wide margin
    localparam int MAX_CYCLES = 2000;

    logic clk;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    bus_addr_t wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic wb_ack;

    integer seed;
    int cycle_count;
    int errors;
    int tests_passed;
    int tests_failed;
    string test_name;

    decode_top i_dut (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: the bus stopped answering within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic word_t rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] sa,
                                         input logic [5:0] funct);
        return {6'b000000, rs, rt, rd, sa, funct};
    endfunction

    function automatic word_t itype_word(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jtype_word(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    // index in 4:0 with write enable at 8 and exception code at 20:16
    function automatic word_t expected_dest(input reg_idx_t idx, input logic we,
                                            input exc_code_t exc);
        return {11'b0, exc, 7'b0, we, 3'b0, idx};
    endfunction

    // starts just after a rising edge and returns on the falling edge with ack high
    task automatic wait_ack();
        @(negedge clk);
        while (!wb_ack)
            @(negedge clk);
    endtask

    task automatic bus_write(input bus_addr_t adr, input word_t data);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= adr;
        wb_dat_w <= data;
        wait_ack();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t adr, output word_t data);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic compare_read(input bus_addr_t adr, input word_t exp, input string what);
        word_t got;
        bus_read(adr, got);
        if (got !== exp)
        begin
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, got);
            errors++;
        end
    endtask

    task automatic check_decode(input string mnem, input word_t inst, input word_t pc,
                                input word_t rs, input word_t rt, input exc_code_t fexc,
                                input decode_ctrl_t exp_ctrl, input word_t exp_a,
                                input word_t exp_b, input word_t exp_target,
                                input word_t exp_dest);
        bus_write(`ADDR_PC, pc);
        bus_write(`ADDR_RS, rs);
        bus_write(`ADDR_RT, rt);
        bus_write(`ADDR_FEXC, {27'b0, fexc});
        bus_write(`ADDR_INST, inst);
        compare_read(`ADDR_CTRL, word_t'(exp_ctrl), $sformatf("%s ctrl", mnem));
        compare_read(`ADDR_ALU_A, exp_a, $sformatf("%s alu_a", mnem));
        compare_read(`ADDR_ALU_B, exp_b, $sformatf("%s alu_b", mnem));
        compare_read(`ADDR_TARGET, exp_target, $sformatf("%s target", mnem));
        compare_read(`ADDR_DEST, exp_dest, $sformatf("%s dest", mnem));
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors = 0;
    endtask

    task automatic finish_test();
        if (errors == 0)
        begin
            $display("%s: ok", test_name);
            tests_passed++;
        end
        else
        begin
            $display("%s: %0d errors", test_name, errors);
            tests_failed++;
        end
    endtask

    task automatic reset_and_readback();
        word_t v_inst;
        word_t v_pc;
        word_t v_rs;
        word_t v_rt;
        word_t v_fexc;
        start_test("reset_readback");
        compare_read(`ADDR_INST, '0, "inst after reset");
        compare_read(`ADDR_PC, '0, "pc after reset");
        compare_read(`ADDR_RS, '0, "rs after reset");
        compare_read(`ADDR_RT, '0, "rt after reset");
        compare_read(`ADDR_FEXC, '0, "fexc after reset");
        compare_read(8'h40, '0, "unmapped address");
        v_inst = $random(seed);
        v_pc = $random(seed);
        v_rs = $random(seed);
        v_rt = $random(seed);
        v_fexc = $random(seed);
        bus_write(`ADDR_INST, v_inst);
        bus_write(`ADDR_PC, v_pc);
        bus_write(`ADDR_RS, v_rs);
        bus_write(`ADDR_RT, v_rt);
        bus_write(`ADDR_FEXC, v_fexc);
        compare_read(`ADDR_INST, v_inst, "inst readback");
        compare_read(`ADDR_PC, v_pc, "pc readback");
        compare_read(`ADDR_RS, v_rs, "rs readback");
        compare_read(`ADDR_RT, v_rt, "rt readback");
        compare_read(`ADDR_FEXC, {27'b0, v_fexc[4:0]}, "fexc readback");
        finish_test();
    endtask

    task automatic rtype_alu_shifts();
        word_t rs;
        word_t rt;
        word_t r;
        exc_code_t fexc;
        decode_ctrl_t c;
        start_test("rtype_ops");
        rs = $random(seed);
        rt = $random(seed);
        r = $random(seed);
        fexc = r[4:0];
        c = '0;
        c.op_add = 1'b1;
        check_decode("add", rtype_word(5'd3, 5'd4, 5'd5, 5'd0, 6'h20), 32'h0040_0000,
                     rs, rt, fexc, c, rs, rt, '0, expected_dest(5'd5, 1'b1, fexc));
        c = '0;
        c.op_nor = 1'b1;
        check_decode("nor", rtype_word(5'd1, 5'd2, 5'd6, 5'd0, 6'h27), 32'h0040_0004,
                     rs, rt, fexc, c, rs, rt, '0, expected_dest(5'd6, 1'b1, fexc));
        // shifts take rt as operand A
        c = '0;
        c.op_sll = 1'b1;
        check_decode("sllv", rtype_word(5'd6, 5'd7, 5'd8, 5'd0, 6'h04), 32'h0040_0008,
                     rs, rt, fexc, c, rt, rs, '0, expected_dest(5'd8, 1'b1, fexc));
        c = '0;
        c.op_sra = 1'b1;
        check_decode("sra", rtype_word(5'd0, 5'd9, 5'd10, 5'd7, 6'h03), 32'h0040_000c,
                     rs, rt, fexc, c, rt, 32'd7, '0, expected_dest(5'd10, 1'b1, fexc));
        finish_test();
    endtask

    task automatic immediate_operands();
        word_t rs;
        word_t rt;
        word_t r;
        exc_code_t fexc;
        decode_ctrl_t c;
        start_test("immediates");
        rs = $random(seed);
        rt = $random(seed);
        r = $random(seed);
        fexc = r[4:0];
        c = '0;
        c.op_add = 1'b1;
        check_decode("addi", itype_word(6'h08, 5'd2, 5'd9, 16'hff80), 32'h0040_0010,
                     rs, rt, fexc, c, rs, 32'hffff_ff80, '0, expected_dest(5'd9, 1'b1, fexc));
        c = '0;
        c.op_or = 1'b1;
        check_decode("ori", itype_word(6'h0d, 5'd2, 5'd11, 16'h8001), 32'h0040_0014,
                     rs, rt, fexc, c, rs, 32'h0000_8001, '0, expected_dest(5'd11, 1'b1, fexc));
        c = '0;
        c.op_lui = 1'b1;
        check_decode("lui", itype_word(6'h0f, 5'd0, 5'd12, 16'h1234), 32'h0040_0018,
                     rs, rt, fexc, c, rs, 32'h1234_0000, '0, expected_dest(5'd12, 1'b1, fexc));
        finish_test();
    endtask

    task automatic branches_and_jumps();
        word_t rs;
        word_t rt;
        word_t r;
        word_t inst;
        word_t pc;
        word_t slot;
        exc_code_t fexc;
        decode_ctrl_t c;
        start_test("branches_jumps");
        rs = $random(seed);
        rt = $random(seed);
        r = $random(seed);
        fexc = r[4:0];
        // offset of -4 words back from the delay slot
        pc = 32'h0000_1000;
        c = '0;
        c.br_eq = 1'b1;
        c.branch_jump = 1'b1;
        check_decode("beq", itype_word(6'h04, 5'd1, 5'd2, 16'hfffc), pc, rs, rt, fexc, c,
                     rs, rt, pc + 32'd4 - 32'd16, expected_dest(5'd2, 1'b0, fexc));
        pc = 32'h5000_0100;
        slot = pc + 32'd4;
        inst = jtype_word(6'h02, 26'h012_3456);
        c = '0;
        c.jump = 1'b1;
        c.branch_jump = 1'b1;
        check_decode("j", inst, pc, rs, rt, fexc, c, rs, rt,
                     {slot[31:28], 26'h012_3456, 2'b00},
                     expected_dest(inst[20:16], 1'b0, fexc));
        // rd is not 31 here, the link register still wins
        c = '0;
        c.op_link = 1'b1;
        c.jump = 1'b1;
        c.branch_jump = 1'b1;
        check_decode("jalr", rtype_word(5'd6, 5'd0, 5'd7, 5'd0, 6'h09), 32'h0000_2000,
                     rs, rt, fexc, c, rs, rt, rs, expected_dest(5'd31, 1'b1, fexc));
        c = '0;
        c.op_link = 1'b1;
        c.br_gez = 1'b1;
        c.branch_jump = 1'b1;
        check_decode("bgezal", itype_word(6'h01, 5'd3, 5'd17, 16'h0010), 32'h0000_3000,
                     rs, rt, fexc, c, rs, rt, 32'h0000_3044,
                     expected_dest(5'd31, 1'b1, fexc));
        finish_test();
    endtask

    task automatic exception_codes();
        word_t rs;
        word_t rt;
        start_test("exceptions");
        rs = $random(seed);
        rt = $random(seed);
        check_decode("syscall", 32'h0000_000c, 32'h0000_0400, rs, rt, 5'd0, '0,
                     rs, rt, '0, expected_dest(5'd0, 1'b0, 5'd`EXC_SYS));
        check_decode("break", 32'h0000_000d, 32'h0000_0404, rs, rt, 5'd0, '0,
                     rs, rt, '0, expected_dest(5'd0, 1'b0, 5'd`EXC_BP));
        // lw is not decoded so it counts as reserved
        check_decode("reserved", itype_word(6'h23, 5'd1, 5'd2, 16'h0010), 32'h0000_0408,
                     rs, rt, 5'd0, '0, rs, rt, '0, expected_dest(5'd2, 1'b0, 5'd`EXC_RI));
        check_decode("misaligned", rtype_word(5'd3, 5'd4, 5'd5, 5'd0, 6'h20), 32'h0000_1002,
                     rs, rt, 5'h06, '0, rs, rt, '0, expected_dest(5'd4, 1'b0, 5'h06));
        finish_test();
    endtask

    initial
    begin
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        seed = 32'hbc96;
        cycle_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        reset_and_readback();
        rtype_alu_shifts();
        immediate_operands();
        branches_and_jumps();
        exception_codes();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+hw
hw/decode_pkg.sv
hw/inst_classify.sv
hw/operand_select.sv
hw/branch_target.sv
hw/decode_regs.sv
hw/decode_top.sv
bench/decode_properties.sv
bench/decode_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decode_tb -f build.f -o decode_sim
./obj_dir/decode_sim > sim.log
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
